//--- Bender.yml
package:
  name: bilinear_scaler

sources:
  - files:
      - source/pixel_pkg.sv
      - source/scale_pkg.sv
      - source/line_writer.sv
      - source/line_ram.sv
      - source/row_fifo.sv
      - source/scale_sequencer.sv
      - source/interp_pipeline.sv
      - source/bilinear_scaler.sv
  - target: test
    files:
      - tests/scaler_properties.sv
      - tests/tb_bilinear_scaler.sv

//--- flist.f
source/pixel_pkg.sv
source/scale_pkg.sv
source/line_writer.sv
source/line_ram.sv
source/row_fifo.sv
source/scale_sequencer.sv
source/interp_pipeline.sv
source/bilinear_scaler.sv
tests/scaler_properties.sv
tests/tb_bilinear_scaler.sv

//--- source/bilinear_scaler.sv
/*
 * bilinear image scaler top, fixed ratios from the size parameters,
 * line buffer, row FIFO, sequencer and blend pipeline
 */
`timescale 1ns/1ps

module bilinear_scaler #(
    parameter int SRC_W = 640,
    parameter int SRC_H = 480,
    parameter int DST_W = 640,
    parameter int DST_H = 480
) (
    input  logic              clk_in2,
    input  logic              rst_n,
    input  logic              mode_i,
    input  logic              in_vsync_i,
    input  logic              in_href_i,
    input  pixel_pkg::pixel_t in_pixel_i,
    output logic              out_vsync_o,
    output logic              out_href_o,
    output pixel_pkg::pixel_t out_pixel_o
);

    // floor(src * 2^16 / dst)
    localparam scale_pkg::ratio_t X_RATIO =
        scale_pkg::ratio_t'((SRC_W * scale_pkg::ONE) / DST_W);
    localparam scale_pkg::ratio_t Y_RATIO =
        scale_pkg::ratio_t'((SRC_H * scale_pkg::ONE) / DST_H);

    scale_pkg::ram_addr_t wr_addr;
    pixel_pkg::pixel_t    wr_pixel;
    logic                 wr_en_a, wr_en_b;
    logic                 push, pop, empty, full;
    scale_pkg::coord_t    push_row, head_row;
    scale_pkg::pos_t      x_pos, y_pos;
    logic                 seq_href, seq_vsync;
    scale_pkg::ram_addr_t raddr_even_a, raddr_odd_a, raddr_even_b, raddr_odd_b;
    pixel_pkg::pixel_t    rd_even_a, rd_odd_a, rd_even_b, rd_odd_b;

    // --------------------
    // write side
    line_writer #(.SRC_W(SRC_W)) u_writer (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .in_vsync_i (in_vsync_i),
        .in_href_i  (in_href_i),
        .in_pixel_i (in_pixel_i),
        .wr_addr_o  (wr_addr),
        .wr_pixel_o (wr_pixel),
        .wr_en_a_o  (wr_en_a),
        .wr_en_b_o  (wr_en_b),
        .push_o     (push),
        .push_row_o (push_row)
    );

    // each bank twice, even and odd column taps in one cycle
    line_ram u_ram_even_a (.clk_in2(clk_in2), .we_i(wr_en_a), .waddr_i(wr_addr),
        .wdata_i(wr_pixel), .raddr_i(raddr_even_a), .rdata_o(rd_even_a));
    line_ram u_ram_odd_a (.clk_in2(clk_in2), .we_i(wr_en_a), .waddr_i(wr_addr),
        .wdata_i(wr_pixel), .raddr_i(raddr_odd_a), .rdata_o(rd_odd_a));
    line_ram u_ram_even_b (.clk_in2(clk_in2), .we_i(wr_en_b), .waddr_i(wr_addr),
        .wdata_i(wr_pixel), .raddr_i(raddr_even_b), .rdata_o(rd_even_b));
    line_ram u_ram_odd_b (.clk_in2(clk_in2), .we_i(wr_en_b), .waddr_i(wr_addr),
        .wdata_i(wr_pixel), .raddr_i(raddr_odd_b), .rdata_o(rd_odd_b));

    row_fifo #(.DEPTH(4)) u_fifo (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .push_i     (push),
        .push_row_i (push_row),
        .pop_i      (pop),
        .head_row_o (head_row),
        .empty_o    (empty),
        .full_o     (full)
    );

    // --------------------
    // read side
    scale_sequencer #(
        .SRC_H   (SRC_H),
        .DST_W   (DST_W),
        .DST_H   (DST_H),
        .X_RATIO (X_RATIO),
        .Y_RATIO (Y_RATIO)
    ) u_seq (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .empty_i     (empty),
        .head_row_i  (head_row),
        .pop_o       (pop),
        .x_pos_o     (x_pos),
        .y_pos_o     (y_pos),
        .seq_href_o  (seq_href),
        .seq_vsync_o (seq_vsync)
    );

    interp_pipeline #(.SRC_W(SRC_W), .SRC_H(SRC_H)) u_pipe (
        .clk_in2        (clk_in2),
        .rst_n          (rst_n),
        .mode_i         (mode_i),
        .x_pos_i        (x_pos),
        .y_pos_i        (y_pos),
        .seq_href_i     (seq_href),
        .seq_vsync_i    (seq_vsync),
        .rd_even_a_i    (rd_even_a),
        .rd_odd_a_i     (rd_odd_a),
        .rd_even_b_i    (rd_even_b),
        .rd_odd_b_i     (rd_odd_b),
        .raddr_even_a_o (raddr_even_a),
        .raddr_odd_a_o  (raddr_odd_a),
        .raddr_even_b_o (raddr_even_b),
        .raddr_odd_b_o  (raddr_odd_b),
        .out_href_o     (out_href_o),
        .out_vsync_o    (out_vsync_o),
        .out_pixel_o    (out_pixel_o)
    );

endmodule

//--- source/interp_pipeline.sv
/*
 * bilinear blend pipeline, weights, neighbour fetch, edge replication,
 * rounding and nearest-tap select, 11 cycles from position to pixel
 */
`timescale 1ns/1ps

module interp_pipeline #(
    parameter int SRC_W = 640,
    parameter int SRC_H = 480
) (
    input  logic                 clk_in2,
    input  logic                 rst_n,
    input  logic                 mode_i,
    input  scale_pkg::pos_t      x_pos_i,
    input  scale_pkg::pos_t      y_pos_i,
    input  logic                 seq_href_i,
    input  logic                 seq_vsync_i,
    input  pixel_pkg::pixel_t    rd_even_a_i,
    input  pixel_pkg::pixel_t    rd_odd_a_i,
    input  pixel_pkg::pixel_t    rd_even_b_i,
    input  pixel_pkg::pixel_t    rd_odd_b_i,
    output scale_pkg::ram_addr_t raddr_even_a_o,
    output scale_pkg::ram_addr_t raddr_odd_a_o,
    output scale_pkg::ram_addr_t raddr_even_b_o,
    output scale_pkg::ram_addr_t raddr_odd_b_o,
    output logic                 out_href_o,
    output logic                 out_vsync_o,
    output pixel_pkg::pixel_t    out_pixel_o
);

    // framing, stages c1 .. c10
    logic [9:0] href_sr;
    logic [9:0] vsync_sr;

    scale_pkg::coord_t    x_int_c1, y_int_c1, y_nxt_c1;
    scale_pkg::weight_t   x_fra_c1, x_inv_c1, y_fra_c1, y_inv_c1;
    scale_pkg::ram_addr_t addr_cur_c2, addr_nxt_c2;
    // taps and weights indexed 00, 01, 10, 11
    scale_pkg::area_t     w_c2 [4], w_c3 [4], w_c4 [4], w_c5 [4], w_c6 [4];
    // flags: odd row, right edge, bottom edge, y nearest, x nearest
    logic [4:0]           flg_c2, flg_c3, flg_c4, flg_c5, flg_c6;
    pixel_pkg::pixel_t    p_c5 [4], p_c6 [4];
    logic [41:0]          prod_c7 [4];
    logic [42:0]          sum01_c8, sum23_c8;
    logic [43:0]          sum_c9;
    logic [11:0]          round_c10;
    pixel_pkg::pixel_t    near_c7, near_c8, near_c9, near_c10;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            href_sr  <= '0;
            vsync_sr <= '0;
        end
        else
        begin
            href_sr  <= {href_sr[8:0], seq_href_i};
            vsync_sr <= {vsync_sr[8:0], seq_vsync_i};
        end
    end

    // --------------------
    // c1 split position into integer and fraction
    always_ff @(posedge clk_in2)
    begin
        x_int_c1 <= x_pos_i[26:16];
        y_int_c1 <= y_pos_i[26:16];
        x_fra_c1 <= {1'b0, x_pos_i[15:0]};
        y_fra_c1 <= {1'b0, y_pos_i[15:0]};
        x_inv_c1 <= scale_pkg::weight_t'(scale_pkg::ONE - x_pos_i[15:0]);
        y_inv_c1 <= scale_pkg::weight_t'(scale_pkg::ONE - y_pos_i[15:0]);
    end

    assign y_nxt_c1 = y_int_c1 + 11'd1;

    // c2 area weights, line addresses, edge and nearest flags
    always_ff @(posedge clk_in2)
    begin
        w_c2[0]     <= x_inv_c1 * y_inv_c1;
        w_c2[1]     <= x_fra_c1 * y_inv_c1;
        w_c2[2]     <= x_inv_c1 * y_fra_c1;
        w_c2[3]     <= x_fra_c1 * y_fra_c1;
        addr_cur_c2 <= scale_pkg::ram_addr_t'(y_int_c1[1] ? scale_pkg::LINE_STRIDE : 0)
                     + scale_pkg::ram_addr_t'(x_int_c1);
        addr_nxt_c2 <= scale_pkg::ram_addr_t'(y_nxt_c1[1] ? scale_pkg::LINE_STRIDE : 0)
                     + scale_pkg::ram_addr_t'(x_int_c1);
        flg_c2      <= {y_int_c1[0],
                        x_int_c1 == scale_pkg::coord_t'(SRC_W - 1),
                        y_int_c1 == scale_pkg::coord_t'(SRC_H - 1),
                        y_fra_c1 >= y_inv_c1,
                        x_fra_c1 >= x_inv_c1};
    end

    // --------------------
    // c3 read addresses, odd row takes its next row from bank a
    always_ff @(posedge clk_in2)
    begin
        raddr_even_a_o <= flg_c2[4] ? addr_nxt_c2 : addr_cur_c2;
        raddr_odd_a_o  <= (flg_c2[4] ? addr_nxt_c2 : addr_cur_c2) + 12'd1;
        raddr_even_b_o <= addr_cur_c2;
        raddr_odd_b_o  <= addr_cur_c2 + 12'd1;
    end

    // side data rides along until the multiply
    always_ff @(posedge clk_in2)
    begin
        w_c3   <= w_c2;
        w_c4   <= w_c3;
        w_c5   <= w_c4;
        w_c6   <= w_c5;
        flg_c3 <= flg_c2;
        flg_c4 <= flg_c3;
        flg_c5 <= flg_c4;
        flg_c6 <= flg_c5;
    end

    // c5 order taps into top and bottom rows, RAM data valid in c4
    always_ff @(posedge clk_in2)
    begin
        if (!flg_c4[4])
        begin
            p_c5[0] <= rd_even_a_i;
            p_c5[1] <= rd_odd_a_i;
            p_c5[2] <= rd_even_b_i;
            p_c5[3] <= rd_odd_b_i;
        end
        else
        begin
            p_c5[0] <= rd_even_b_i;
            p_c5[1] <= rd_odd_b_i;
            p_c5[2] <= rd_even_a_i;
            p_c5[3] <= rd_odd_a_i;
        end
    end

    // c6 replicate past the right and bottom edges
    always_ff @(posedge clk_in2)
    begin
        p_c6[0] <= p_c5[0];
        p_c6[1] <= flg_c5[3] ? p_c5[0] : p_c5[1];
        p_c6[2] <= flg_c5[2] ? p_c5[0] : p_c5[2];
        if (flg_c5[3])
            p_c6[3] <= flg_c5[2] ? p_c5[0] : p_c5[2];
        else
            p_c6[3] <= flg_c5[2] ? p_c5[1] : p_c5[3];
    end

    // --------------------
    // c7 .. c10 multiply, adder tree, round on bit 31
    always_ff @(posedge clk_in2)
    begin
        for (int i = 0; i < 4; i++)
            prod_c7[i] <= w_c6[i] * p_c6[i];
        near_c7   <= p_c6[flg_c6[1:0]];
        sum01_c8  <= prod_c7[0] + prod_c7[1];
        sum23_c8  <= prod_c7[2] + prod_c7[3];
        near_c8   <= near_c7;
        sum_c9    <= sum01_c8 + sum23_c8;
        near_c9   <= near_c8;
        round_c10 <= sum_c9[43:32] + 12'(sum_c9[31]);
        near_c10  <= near_c9;
    end

    // c11 saturate and pick blend or nearest tap
    always_ff @(posedge clk_in2)
    begin
        if (round_c10 > 12'(pixel_pkg::PIX_MAX))
            out_pixel_o <= pixel_pkg::PIX_MAX;
        else if (mode_i)
            out_pixel_o <= round_c10[7:0];
        else
            out_pixel_o <= near_c10;
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            out_href_o  <= 1'b0;
            out_vsync_o <= 1'b0;
        end
        else
        begin
            out_href_o  <= href_sr[9];
            out_vsync_o <= vsync_sr[9];
        end
    end

endmodule

//--- source/line_ram.sv
/*
 * one line-buffer RAM, write port and registered read port
 */
`timescale 1ns/1ps

module line_ram (
    input  logic                 clk_in2,
    input  logic                 we_i,
    input  scale_pkg::ram_addr_t waddr_i,
    input  pixel_pkg::pixel_t    wdata_i,
    input  scale_pkg::ram_addr_t raddr_i,
    output pixel_pkg::pixel_t    rdata_o
);

    // 4096 entries, two lines of one bank
    pixel_pkg::pixel_t mem [2**$bits(scale_pkg::ram_addr_t)];

    always_ff @(posedge clk_in2)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        // data one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- source/line_writer.sv
/*
 * source line writer, counts rows and columns, writes the line banks
 * and pushes the index of every completed row
 */
`timescale 1ns/1ps

module line_writer #(
    parameter int SRC_W = 640
) (
    input  logic                 clk_in2,
    input  logic                 rst_n,
    input  logic                 in_vsync_i,
    input  logic                 in_href_i,
    input  pixel_pkg::pixel_t    in_pixel_i,
    output scale_pkg::ram_addr_t wr_addr_o,
    output pixel_pkg::pixel_t    wr_pixel_o,
    output logic                 wr_en_a_o,
    output logic                 wr_en_b_o,
    output logic                 push_o,
    output scale_pkg::coord_t    push_row_o
);

    logic              href_d;
    logic              pix_vld;
    scale_pkg::coord_t row_cnt;
    scale_pkg::coord_t col_cnt;

    assign pix_vld = in_vsync_i & in_href_i;

    // --------------------
    // row and column counters
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            href_d  <= 1'b0;
            row_cnt <= '0;
            col_cnt <= '0;
        end
        else
        begin
            href_d <= in_href_i;
            // row restarts outside the frame, steps on falling href
            if (!in_vsync_i)
                row_cnt <= '0;
            else if (href_d && !in_href_i)
                row_cnt <= row_cnt + 11'd1;
            if (pix_vld)
                col_cnt <= col_cnt + 11'd1;
            else
                col_cnt <= '0;
        end
    end

    // --------------------
    // write port, one cycle behind the input
    always_ff @(posedge clk_in2)
    begin
        wr_pixel_o <= in_pixel_i;
        // row bit 1 picks the line inside a bank
        wr_addr_o  <= scale_pkg::ram_addr_t'(row_cnt[1] ? scale_pkg::LINE_STRIDE : 0)
                    + scale_pkg::ram_addr_t'(col_cnt);
        push_row_o <= row_cnt;
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            wr_en_a_o <= 1'b0;
            wr_en_b_o <= 1'b0;
            push_o    <= 1'b0;
        end
        else
        begin
            // even rows to bank a, odd rows to bank b
            wr_en_a_o <= pix_vld & ~row_cnt[0];
            wr_en_b_o <= pix_vld & row_cnt[0];
            // row done on its last column
            push_o    <= pix_vld && (col_cnt == scale_pkg::coord_t'(SRC_W - 1));
        end
    end

endmodule

//--- source/pixel_pkg.sv
/*
 * pixel format of the grey video path
 */
package pixel_pkg;

    // one grey sample
    typedef logic [7:0] pixel_t;

    // saturation limit of the blend
    localparam pixel_t PIX_MAX = 8'd255;

endpackage

//--- source/row_fifo.sv
/*
 * small synchronous FIFO of completed source row indices
 */
`timescale 1ns/1ps

module row_fifo #(
    parameter int DEPTH = 4
) (
    input  logic              clk_in2,
    input  logic              rst_n,
    input  logic              push_i,
    input  scale_pkg::coord_t push_row_i,
    input  logic              pop_i,
    output scale_pkg::coord_t head_row_o,
    output logic              empty_o,
    output logic              full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    scale_pkg::coord_t    mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    // push into a full FIFO is dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_in2)
    begin
        if (do_push)
            mem[wr_ptr] <= push_row_i;
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // head visible the cycle after the push
    assign head_row_o = mem[rd_ptr];
    assign empty_o    = (count == '0);
    assign full_o     = (count == ($bits(count))'(DEPTH));

endmodule

//--- source/scale_pkg.sv
/*
 * fixed-point and line-buffer geometry of the scaler
 * positions are 16.16, weights and areas unsigned
 */
package scale_pkg;

    // fraction bits of a position
    localparam int unsigned FRAC_W = 16;
    // weight of a whole pixel
    localparam int unsigned ONE = 1 << FRAC_W;

    // integer pixel or row index
    typedef logic [10:0] coord_t;
    // accumulated 16.16 position
    typedef logic [26:0] pos_t;
    // step per destination pixel or row
    typedef logic [16:0] ratio_t;
    // 1-d weight, 0 .. ONE
    typedef logic [16:0] weight_t;
    // product of two weights
    typedef logic [33:0] area_t;

    // address distance between the two lines of one bank
    localparam int unsigned LINE_STRIDE = 1024;
    typedef logic [11:0] ram_addr_t;

endpackage

//--- source/scale_sequencer.sv
/*
 * destination sequencer, steps rows and columns against the buffered
 * source rows and issues 16.16 source positions with framing
 */
`timescale 1ns/1ps

module scale_sequencer #(
    parameter int                SRC_H   = 480,
    parameter int                DST_W   = 640,
    parameter int                DST_H   = 480,
    parameter scale_pkg::ratio_t X_RATIO = 17'h10000,
    parameter scale_pkg::ratio_t Y_RATIO = 17'h10000
) (
    input  logic              clk_in2,
    input  logic              rst_n,
    input  logic              empty_i,
    input  scale_pkg::coord_t head_row_i,
    output logic              pop_o,
    output scale_pkg::pos_t   x_pos_o,
    output scale_pkg::pos_t   y_pos_o,
    output logic              seq_href_o,
    output logic              seq_vsync_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ROW_CHK,
        S_EMIT,
        S_ROW_ADV,
        S_POP
    } state_t;

    state_t            state;
    scale_pkg::pos_t   x_acc;
    scale_pkg::pos_t   y_acc;
    scale_pkg::coord_t x_cnt;
    scale_pkg::coord_t y_cnt;
    logic              restart;
    logic              row_ready;
    logic              x_last;
    logic              frame_done;

    // head 0 starts a new destination frame
    assign restart    = (state == S_IDLE) && !empty_i && (head_row_i == '0);
    // both source rows of y are buffered, or no more rows will come
    assign row_ready  = ({1'b0, y_acc[26:16]} + 12'd1 <= {1'b0, head_row_i})
                     || (head_row_i == scale_pkg::coord_t'(SRC_H - 1));
    assign x_last     = (x_cnt == scale_pkg::coord_t'(DST_W - 1));
    assign frame_done = (y_cnt == scale_pkg::coord_t'(DST_H));

    // --------------------
    // FSM
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                begin
                    // rows after a finished frame are just dropped
                    if (!empty_i)
                        state <= (head_row_i != '0 && frame_done) ? S_POP : S_ROW_CHK;
                end
                S_ROW_CHK:
                    state <= row_ready ? S_EMIT : S_POP;
                S_EMIT:
                begin
                    if (x_last)
                        state <= S_ROW_ADV;
                end
                S_ROW_ADV:
                    state <= (y_cnt == scale_pkg::coord_t'(DST_H - 1)) ? S_POP : S_ROW_CHK;
                S_POP:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // --------------------
    // vertical position, count starts out of frame
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            y_acc <= '0;
            y_cnt <= scale_pkg::coord_t'(DST_H);
        end
        else if (restart)
        begin
            y_acc <= '0;
            y_cnt <= '0;
        end
        else if (state == S_ROW_ADV)
        begin
            y_acc <= y_acc + Y_RATIO;
            y_cnt <= y_cnt + 11'd1;
        end
    end

    // horizontal position, one step per emitted pixel
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || state != S_EMIT)
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
        else
        begin
            x_acc <= x_acc + X_RATIO;
            x_cnt <= x_cnt + 11'd1;
        end
    end

    // frame level, rises with pixel 0 of row 0
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            seq_vsync_o <= 1'b0;
        else if (state == S_ROW_CHK && row_ready && y_cnt == '0)
            seq_vsync_o <= 1'b1;
        else if (state == S_EMIT && x_last && y_cnt == scale_pkg::coord_t'(DST_H - 1))
            seq_vsync_o <= 1'b0;
    end

    assign pop_o      = (state == S_POP);
    assign seq_href_o = (state == S_EMIT);
    assign x_pos_o    = x_acc;
    assign y_pos_o    = y_acc;

endmodule

//--- tests/scaler_properties.sv
/*
 * output framing and row FIFO assertions, bound into the scaler top
 */
`timescale 1ns/1ps

module scaler_properties #(
    parameter int DST_W = 640
) (
    input logic clk_in2,
    input logic rst_n,
    input logic out_href_i,
    input logic out_vsync_i,
    input logic push_i,
    input logic full_i
);

    int run_len;

    // length of the current href run
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            run_len <= 0;
        else if (out_href_i)
            run_len <= run_len + 1;
        else
            run_len <= 0;
    end

    // --------------------
    // pixels only inside the frame
    href_in_vsync: assert property (@(posedge clk_in2) disable iff (!rst_n)
        out_href_i |-> out_vsync_i)
        else $error("out_href_o high while out_vsync_o is low");

    // no run longer than one line
    href_not_long: assert property (@(posedge clk_in2) disable iff (!rst_n)
        out_href_i |-> run_len < DST_W)
        else $error("out_href_o run longer than DST_W");

    // and none shorter
    href_full_line: assert property (@(posedge clk_in2) disable iff (!rst_n)
        $fell(out_href_i) |-> run_len == DST_W)
        else $error("out_href_o run ended with %0d pixels", run_len);

    // no dropped row index
    push_not_full: assert property (@(posedge clk_in2) disable iff (!rst_n)
        push_i |-> !full_i)
        else $error("push into a full row FIFO");

endmodule

bind bilinear_scaler scaler_properties #(.DST_W(DST_W)) u_props (
    .clk_in2     (clk_in2),
    .rst_n       (rst_n),
    .out_href_i  (out_href_o),
    .out_vsync_i (out_vsync_o),
    .push_i      (push),
    .full_i      (full)
);

//--- tests/tb_bilinear_scaler.sv
/*
 * testbench for the bilinear scaler
 * random frames in both modes checked pixel by pixel against a reference model
 */
`timescale 1ns/1ps

module tb_bilinear_scaler;

    localparam int SRC_W         = 16;
    localparam int SRC_H         = 12;
    localparam int DST_W         = 24;
    localparam int DST_H         = 18;
    localparam int N_FRAMES      = 5;
    localparam int LINE_GAP      = 100;
    localparam int FRAME_TIMEOUT = 5000;
    // floor(src * 2^16 / dst)
    localparam longint X_STEP = (longint'(SRC_W) * scale_pkg::ONE) / DST_W;
    localparam longint Y_STEP = (longint'(SRC_H) * scale_pkg::ONE) / DST_H;

    logic              clk_in2;
    logic              rst_n;
    logic              mode_i;
    logic              in_vsync_i;
    logic              in_href_i;
    pixel_pkg::pixel_t in_pixel_i;
    logic              out_vsync_o;
    logic              out_href_o;
    pixel_pkg::pixel_t out_pixel_o;

    // current source frame and the collected output
    pixel_pkg::pixel_t src_img [SRC_W*SRC_H];
    pixel_pkg::pixel_t exp_q [$];
    pixel_pkg::pixel_t got_q [$];
    int                errors;
    int                checks;
    int                timeouts;
    int                run_len;
    int                line_cnt;
    int                vs_rise;
    logic              href_prev;
    logic              vs_prev;
    logic              frame_end;

    bilinear_scaler #(
        .SRC_W (SRC_W),
        .SRC_H (SRC_H),
        .DST_W (DST_W),
        .DST_H (DST_H)
    ) dut (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .mode_i      (mode_i),
        .in_vsync_i  (in_vsync_i),
        .in_href_i   (in_href_i),
        .in_pixel_i  (in_pixel_i),
        .out_vsync_o (out_vsync_o),
        .out_href_o  (out_href_o),
        .out_pixel_o (out_pixel_o)
    );

    // 40 ns period
    always #20 clk_in2 = ~clk_in2;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error at time %0t: %s, got %0d expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    // --------------------
    // reference model of one destination pixel
    function automatic pixel_pkg::pixel_t expect_pixel(input int i, input int j,
                                                       input logic blend);
        longint xp, yp, xf, yf, xinv, yinv, acc, rounded;
        int     xi, yi, x1, y1, sel;
        longint w [4];
        int     tap [4];
        xp   = longint'(i) * X_STEP;
        yp   = longint'(j) * Y_STEP;
        xi   = int'(xp >> scale_pkg::FRAC_W);
        yi   = int'(yp >> scale_pkg::FRAC_W);
        xf   = xp % scale_pkg::ONE;
        yf   = yp % scale_pkg::ONE;
        xinv = scale_pkg::ONE - xf;
        yinv = scale_pkg::ONE - yf;
        // right and bottom neighbours fall back onto the edge
        x1 = (xi == SRC_W - 1) ? xi : xi + 1;
        y1 = (yi == SRC_H - 1) ? yi : yi + 1;
        tap[0] = src_img[yi*SRC_W + xi];
        tap[1] = src_img[yi*SRC_W + x1];
        tap[2] = src_img[y1*SRC_W + xi];
        tap[3] = src_img[y1*SRC_W + x1];
        w[0] = xinv * yinv;
        w[1] = xf * yinv;
        w[2] = xinv * yf;
        w[3] = xf * yf;
        acc = 0;
        for (int k = 0; k < 4; k++)
            acc += w[k] * tap[k];
        // area sum carries 32 fraction bits
        // rounding adds the top one
        rounded = (acc >> (2 * scale_pkg::FRAC_W)) + ((acc >> (2 * scale_pkg::FRAC_W - 1)) & 1);
        // far side once the fraction reaches half a pixel
        sel = ((2 * yf >= scale_pkg::ONE) ? 2 : 0) + ((2 * xf >= scale_pkg::ONE) ? 1 : 0);
        if (rounded > pixel_pkg::PIX_MAX)
            return pixel_pkg::PIX_MAX;
        else if (blend)
            return pixel_pkg::pixel_t'(rounded);
        else
            return pixel_pkg::pixel_t'(tap[sel]);
    endfunction

    // --------------------
    // output monitor on the falling edge
    always @(negedge clk_in2)
    begin
        if (rst_n)
        begin
            if (out_href_o)
            begin
                got_q.push_back(out_pixel_o);
                run_len++;
                check_value(out_vsync_o, 1, "out_href_o outside out_vsync_o");
            end
            else if (href_prev)
            begin
                check_value(run_len, DST_W, "output line length");
                line_cnt++;
                run_len = 0;
            end
            if (out_vsync_o && !vs_prev)
                vs_rise++;
            if (!out_vsync_o && vs_prev)
                frame_end = 1'b1;
            href_prev = out_href_o;
            vs_prev   = out_vsync_o;
        end
    end

    // feeds one random frame and compares the scaled result
    task automatic run_frame(input int f, input logic blend);
        int    waited;
        string tag;
        for (int k = 0; k < SRC_W*SRC_H; k++)
            src_img[k] = pixel_pkg::pixel_t'($urandom);
        exp_q.delete();
        for (int j = 0; j < DST_H; j++)
            for (int i = 0; i < DST_W; i++)
                exp_q.push_back(expect_pixel(i, j, blend));
        got_q.delete();
        run_len   = 0;
        line_cnt  = 0;
        vs_rise   = 0;
        frame_end = 1'b0;
        tag       = blend ? "bilinear" : "nearest";
        @(negedge clk_in2);
        mode_i     = blend;
        in_vsync_i = 1'b1;
        repeat (4) @(negedge clk_in2);
        for (int r = 0; r < SRC_H; r++)
        begin
            for (int c = 0; c < SRC_W; c++)
            begin
                in_href_i  = 1'b1;
                in_pixel_i = src_img[r*SRC_W + c];
                @(negedge clk_in2);
            end
            in_href_i  = 1'b0;
            in_pixel_i = '0;
            // blanking long enough for the sequencer
            repeat (LINE_GAP) @(negedge clk_in2);
        end
        in_vsync_i = 1'b0;
        repeat (4) @(negedge clk_in2);
        waited = 0;
        while (!frame_end && waited < FRAME_TIMEOUT)
        begin
            @(negedge clk_in2);
            waited++;
        end
        if (!frame_end)
        begin
            timeouts++;
            $display("Timeout: output frame %0d never ended with a falling out_vsync_o", f);
        end
        else
        begin
            check_value(vs_rise, 1, $sformatf("frame %0d out_vsync_o pulses", f));
            check_value(line_cnt, DST_H, $sformatf("frame %0d output lines", f));
            check_value(got_q.size(), DST_W*DST_H, $sformatf("frame %0d pixel count", f));
            for (int k = 0; k < got_q.size() && k < exp_q.size(); k++)
                check_value(got_q[k], exp_q[k], $sformatf("frame %0d %s pixel x %0d y %0d",
                            f, tag, k % DST_W, k / DST_W));
        end
    endtask

    // --------------------
    initial
    begin
        logic first_mode;
        logic blend;
        clk_in2    = 1'b0;
        rst_n      = 1'b0;
        mode_i     = 1'b0;
        in_vsync_i = 1'b0;
        in_href_i  = 1'b0;
        in_pixel_i = '0;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        run_len    = 0;
        line_cnt   = 0;
        vs_rise    = 0;
        href_prev  = 1'b0;
        vs_prev    = 1'b0;
        frame_end  = 1'b0;
        void'($urandom(74));
        repeat (8) @(negedge clk_in2);
        rst_n = 1'b1;
        // quiet outputs before any frame
        for (int k = 0; k < 20; k++)
        begin
            @(negedge clk_in2);
            check_value(out_vsync_o, 0, "out_vsync_o before the first frame");
            check_value(out_href_o, 0, "out_href_o before the first frame");
        end
        // first two frames cover both modes
        first_mode = 1'($urandom % 2);
        for (int f = 0; f < N_FRAMES && timeouts == 0; f++)
        begin
            if (f == 0)
                blend = first_mode;
            else if (f == 1)
                blend = !first_mode;
            else
                blend = 1'($urandom % 2);
            run_frame(f, blend);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
